//--- Bender.yml
package:
  name: cpu

sources:
  - logic/cpuPkg.sv
  - logic/alu.sv
  - logic/regFile.sv
  - logic/controlUnit.sv
  - logic/datapath.sv
  - logic/cpu.sv
  - target: simulation
    files:
      - verification/cpuTb.sv

//--- logic/alu.sv
`timescale 1ns/100ps

module alu import cpuPkg::*; (
	input  word_t  a,
	input  word_t  b,
	input  aluOp_t op,
	output word_t  result
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + 16'd1;
			ALU_SHL: result = {a[14:0], 1'b0};
			// arithmetic, sign bit is kept
			ALU_SHR: result = {a[15], a[15:1]};
			// immediate low byte moves to the upper half
			ALU_LHI: result = {b[7:0], 8'h00};
			default: result = '0;
		endcase
	end

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/100ps

module controlUnit import cpuPkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  word_t       instruction,
	output microState_t microState,
	output aluOp_t      aluOp,
	output logic        aluSrc,
	output logic        zeroExtImm,
	output logic        regDst,
	output logic        linkWrite,
	output logic        memToReg,
	output logic        memRead,
	output logic        memWrite,
	output logic        regWrite,
	output branchCond_t branchCond,
	output pcSrc_t      pcSrc,
	output logic        wwd,
	output logic        isHalted
);

	opcode_t     opcode;
	func_t       func;
	aluOp_t      decodedOp;
	logic        halt;
	logic        writesBack;
	microState_t nextState;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];

	// instruction decode, independent of the micro-state
	always_comb begin
		decodedOp = ALU_ADD;
		aluSrc = 1'b0;
		zeroExtImm = 1'b0;
		regDst = 1'b0;
		linkWrite = 1'b0;
		memToReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchCond = BR_NONE;
		pcSrc = PC_SEQ;
		wwd = 1'b0;
		halt = 1'b0;
		writesBack = 1'b0;
		case (opcode)
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				aluSrc = 1'b1;
				pcSrc = PC_BRANCH;
				// opcodes 0..3 map onto NE, EQ, GZ, LZ
				branchCond = branchCond_t'({1'b0, opcode[1:0]} + 3'd1);
			end
			OP_ADI, OP_ORI, OP_LHI: begin
				aluSrc = 1'b1;
				writesBack = 1'b1;
				zeroExtImm = (opcode == OP_ORI);
				if (opcode == OP_ORI) begin
					decodedOp = ALU_OR;
				end else if (opcode == OP_LHI) begin
					decodedOp = ALU_LHI;
				end
			end
			OP_LWD: begin
				aluSrc = 1'b1;
				memRead = 1'b1;
				memToReg = 1'b1;
				writesBack = 1'b1;
			end
			OP_SWD: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			OP_JMP: pcSrc = PC_TARGET;
			OP_JAL: begin
				pcSrc = PC_TARGET;
				linkWrite = 1'b1;
				writesBack = 1'b1;
			end
			OP_RTYPE: begin
				regDst = 1'b1;
				if (func <= FUNC_SHR) begin
					decodedOp = aluOp_t'({1'b0, func[2:0]});
					writesBack = 1'b1;
				end
				case (func)
					FUNC_JPR: pcSrc = PC_REG;
					FUNC_JRL: begin
						pcSrc = PC_REG;
						linkWrite = 1'b1;
						writesBack = 1'b1;
					end
					FUNC_WWD: wwd = 1'b1;
					FUNC_HLT: halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// fetch borrows the ALU for PC+1
	assign aluOp = (microState == IF2 || microState == IF3) ? ALU_ADD : decodedOp;
	assign regWrite = (microState == WB);
	assign isHalted = (microState == HALTED);

	always_comb begin
		nextState = microState;
		case (microState)
			IF1: nextState = IF2;
			IF2: nextState = IF3;
			IF3: nextState = ID;
			ID: begin
				if (halt) begin
					nextState = HALTED;
				end else if (wwd) begin
					nextState = IF1;
				end else begin
					nextState = EX;
				end
			end
			EX: begin
				if (memRead || memWrite) begin
					nextState = MEM1;
				end else if (writesBack) begin
					nextState = WB;
				end else begin
					nextState = IF1;
				end
			end
			MEM1: nextState = MEM2;
			MEM2: nextState = memRead ? WB : IF1;
			WB: nextState = IF1;
			// only reset leaves HALTED
			default: nextState = microState;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			microState <= IF1;
		end else begin
			microState <= nextState;
		end
	end

endmodule

//--- logic/cpu.sv
`timescale 1ns/100ps

module cpu import cpuPkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	output logic       readM,
	output logic       writeM,
	output word_t      address,
	inout  wire word_t data,
	output word_t      outputPort,
	output logic       outputValid,
	output logic       isHalted
);

	microState_t microState;
	aluOp_t      aluOp;
	logic        aluSrc;
	logic        zeroExtImm;
	logic        regDst;
	logic        linkWrite;
	logic        memToReg;
	logic        memRead;
	logic        memWrite;
	logic        regWrite;
	branchCond_t branchCond;
	pcSrc_t      pcSrc;
	logic        wwd;
	word_t       instruction;

	controlUnit i_controlUnit (
		.clk        (clk),
		.reset_n    (reset_n),
		.instruction(instruction),
		.microState (microState),
		.aluOp      (aluOp),
		.aluSrc     (aluSrc),
		.zeroExtImm (zeroExtImm),
		.regDst     (regDst),
		.linkWrite  (linkWrite),
		.memToReg   (memToReg),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.regWrite   (regWrite),
		.branchCond (branchCond),
		.pcSrc      (pcSrc),
		.wwd        (wwd),
		.isHalted   (isHalted)
	);

	datapath i_datapath (
		.clk        (clk),
		.reset_n    (reset_n),
		.microState (microState),
		.aluOp      (aluOp),
		.aluSrc     (aluSrc),
		.zeroExtImm (zeroExtImm),
		.regDst     (regDst),
		.linkWrite  (linkWrite),
		.memToReg   (memToReg),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.regWrite   (regWrite),
		.branchCond (branchCond),
		.pcSrc      (pcSrc),
		.wwd        (wwd),
		.instruction(instruction),
		.readM      (readM),
		.writeM     (writeM),
		.address    (address),
		.data       (data),
		.outputPort (outputPort),
		.outputValid(outputValid)
	);

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0]  regIdx_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [5:0]  func_t;

	// micro-state sequence of the multicycle FSM
	typedef enum logic [3:0] {
		IF1,
		IF2,
		IF3,
		ID,
		EX,
		MEM1,
		MEM2,
		WB,
		HALTED
	} microState_t;

	// the first eight line up with R-type function codes 0 to 7
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_LHI
	} aluOp_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_NE,
		BR_EQ,
		BR_GZ,
		BR_LZ
	} branchCond_t;

	// next-PC source applied in EX
	typedef enum logic [1:0] {
		PC_SEQ,
		PC_BRANCH,
		PC_TARGET,
		PC_REG
	} pcSrc_t;

	localparam opcode_t OP_BNE   = 4'd0;
	localparam opcode_t OP_BEQ   = 4'd1;
	localparam opcode_t OP_BGZ   = 4'd2;
	localparam opcode_t OP_BLZ   = 4'd3;
	localparam opcode_t OP_ADI   = 4'd4;
	localparam opcode_t OP_ORI   = 4'd5;
	localparam opcode_t OP_LHI   = 4'd6;
	localparam opcode_t OP_LWD   = 4'd7;
	localparam opcode_t OP_SWD   = 4'd8;
	localparam opcode_t OP_JMP   = 4'd9;
	localparam opcode_t OP_JAL   = 4'd10;
	localparam opcode_t OP_RTYPE = 4'd15;

	localparam func_t FUNC_ADD = 6'd0;
	localparam func_t FUNC_SUB = 6'd1;
	localparam func_t FUNC_AND = 6'd2;
	localparam func_t FUNC_ORR = 6'd3;
	localparam func_t FUNC_NOT = 6'd4;
	localparam func_t FUNC_TCP = 6'd5;
	localparam func_t FUNC_SHL = 6'd6;
	localparam func_t FUNC_SHR = 6'd7;
	localparam func_t FUNC_JPR = 6'd25;
	localparam func_t FUNC_JRL = 6'd26;
	localparam func_t FUNC_WWD = 6'd28;
	localparam func_t FUNC_HLT = 6'd29;

	// destination of JAL and JRL
	localparam regIdx_t LINK_REG = 2'd2;

endpackage

//--- logic/datapath.sv
`timescale 1ns/100ps

module datapath import cpuPkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  microState_t microState,
	input  aluOp_t      aluOp,
	input  logic        aluSrc,
	input  logic        zeroExtImm,
	input  logic        regDst,
	input  logic        linkWrite,
	input  logic        memToReg,
	input  logic        memRead,
	input  logic        memWrite,
	input  logic        regWrite,
	input  branchCond_t branchCond,
	input  pcSrc_t      pcSrc,
	input  logic        wwd,
	output word_t       instruction,
	output logic        readM,
	output logic        writeM,
	output word_t       address,
	inout  wire word_t  data,
	output word_t       outputPort,
	output logic        outputValid
);

	word_t   pc;
	word_t   storeData;
	word_t   loadLink;
	regIdx_t rs;
	regIdx_t rt;
	regIdx_t rd;
	regIdx_t writeAddr;
	word_t   writeData;
	word_t   readData1;
	word_t   readData2;
	word_t   immExt;
	word_t   aluA;
	word_t   aluB;
	word_t   aluResult;
	logic    fetchInc;
	logic    takeBranch;

	assign rs = instruction[11:10];
	assign rt = instruction[9:8];
	assign rd = instruction[7:6];

	// ORI takes its immediate unsigned
	assign immExt = zeroExtImm ? {8'h00, instruction[7:0]}
	                           : {{8{instruction[7]}}, instruction[7:0]};

	assign writeAddr = linkWrite ? LINK_REG : (regDst ? rd : rt);
	assign writeData = (memToReg || linkWrite) ? loadLink : aluResult;

	regFile i_regFile (
		.clk        (clk),
		.reset_n    (reset_n),
		.readAddr1  (rs),
		.readAddr2  (rt),
		.writeAddr  (writeAddr),
		.writeData  (writeData),
		.writeEnable(regWrite),
		.readData1  (readData1),
		.readData2  (readData2)
	);

	// PC+1 during IF2/IF3, branch target PC+imm otherwise
	assign fetchInc = (microState == IF2) || (microState == IF3);
	assign aluA = (fetchInc || branchCond != BR_NONE) ? pc : readData1;
	assign aluB = fetchInc ? 16'd1 : (aluSrc ? immExt : readData2);

	alu i_alu (
		.a     (aluA),
		.b     (aluB),
		.op    (aluOp),
		.result(aluResult)
	);

	always_comb begin
		case (branchCond)
			BR_NE:   takeBranch = (readData1 != readData2);
			BR_EQ:   takeBranch = (readData1 == readData2);
			BR_GZ:   takeBranch = !readData1[15] && (readData1 != '0);
			BR_LZ:   takeBranch = readData1[15];
			default: takeBranch = 1'b0;
		endcase
	end

	assign address = (microState == IF1 || microState == IF2) ? pc : aluResult;

	// bus is only driven while a store is in MEM2
	assign data = (microState == MEM2 && memWrite) ? storeData : 'z;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			instruction <= '0;
		end else begin
			case (microState)
				IF2: instruction <= data;
				IF3: pc <= aluResult;
				EX: begin
					case (pcSrc)
						PC_BRANCH: begin
							if (takeBranch) begin
								pc <= aluResult;
							end
						end
						PC_TARGET: pc <= {pc[15:12], instruction[11:0]};
						PC_REG:    pc <= readData1;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// strobes are registered one state ahead of their use
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readM <= 1'b0;
			writeM <= 1'b0;
			outputValid <= 1'b0;
		end else begin
			readM <= (microState == IF1) || (microState == MEM1 && memRead);
			writeM <= (microState == MEM1) && memWrite;
			outputValid <= (microState == ID) && wwd;
		end
	end

	always_ff @(posedge clk) begin
		if (microState == ID && wwd) begin
			outputPort <= readData1;
		end
		if (microState == MEM1 && memWrite) begin
			storeData <= readData2;
		end
		// link value is PC+1, before EX moves the PC
		if (microState == EX && linkWrite) begin
			loadLink <= pc;
		end else if (microState == MEM2 && memRead) begin
			loadLink <= data;
		end
	end

endmodule

//--- logic/regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
	input  logic    clk,
	input  logic    reset_n,
	input  regIdx_t readAddr1,
	input  regIdx_t readAddr2,
	input  regIdx_t writeAddr,
	input  word_t   writeData,
	input  logic    writeEnable,
	output word_t   readData1,
	output word_t   readData2
);

	word_t regs [4];

	// both read ports are asynchronous
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

//--- sim.f
logic/cpuPkg.sv
logic/alu.sv
logic/regFile.sv
logic/controlUnit.sv
logic/datapath.sv
logic/cpu.sv
verification/cpuTb.sv

//--- verification/cpuTb.sv
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

	localparam int MEM_WORDS = 256;
	localparam int STEP_LIMIT = 4000;

	logic       clk;
	logic       reset_n;
	logic       readM;
	logic       writeM;
	word_t      address;
	wire word_t data;
	word_t      outputPort;
	logic       outputValid;
	logic       isHalted;

	word_t       mem [MEM_WORDS];
	word_t       image [MEM_WORDS];
	word_t       refMem [MEM_WORDS];
	word_t       expectedTrace [$];
	int          traceIdx = 0;
	int          putPtr = 0;
	int          cycleCount = 0;
	int          cycleLimit = 0;

	cpu i_cpu (
		.clk        (clk),
		.reset_n    (reset_n),
		.readM      (readM),
		.writeM     (writeM),
		.address    (address),
		.data       (data),
		.outputPort (outputPort),
		.outputValid(outputValid),
		.isHalted   (isHalted)
	);

	// memory answers in the same cycle and ignores upper address bits
	assign data = (readM === 1'b1) ? mem[address[7:0]] : 'z;

	always @(posedge clk) begin
		if (writeM === 1'b1) begin
			mem[address[7:0]] <= data;
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: the run went past its limit of %0d cycles", cycleLimit);
			stopRun();
		end
	end

	function void stopRun();
		$display("TESTS FAILED");
		$fatal(1);
	endfunction

	task automatic checkValue(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED time %0t: %s is 0x%04h, expected 0x%04h",
				$time, name, actual, expected);
			stopRun();
		end
	endtask

	function automatic word_t rType(func_t func, regIdx_t rs, regIdx_t rt, regIdx_t rd);
		return {OP_RTYPE, rs, rt, rd, func};
	endfunction

	function automatic word_t iType(opcode_t op, regIdx_t rs, regIdx_t rt, logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	function automatic word_t wwdInstr(regIdx_t rs);
		return rType(FUNC_WWD, rs, 2'd0, 2'd0);
	endfunction

	task automatic put(input word_t instr);
		image[putPtr] = instr;
		putPtr++;
	endtask

	task automatic clearImage();
		for (int i = 0; i < MEM_WORDS; i++) begin
			// unused words differ in every address bit
			image[i] = {8'(255 - i), 8'(i)};
		end
		putPtr = 0;
	endtask

	// ISA interpreter on a shadow copy of the image
	function automatic int runProgram();
		word_t   regs [4];
		word_t   pc;
		word_t   inst;
		word_t   immS;
		word_t   ea;
		word_t   target;
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t rd;
		int      steps;
		logic    halted;
		for (int i = 0; i < MEM_WORDS; i++) begin
			refMem[i] = image[i];
		end
		for (int r = 0; r < 4; r++) begin
			regs[r] = '0;
		end
		expectedTrace.delete();
		pc = '0;
		steps = 0;
		halted = 1'b0;
		while (!halted) begin
			if (steps >= STEP_LIMIT) begin
				$display("reference program did not reach HLT within %0d steps", STEP_LIMIT);
				stopRun();
			end
			inst = refMem[pc[7:0]];
			// targets and link values start from the incremented PC
			pc = pc + 16'd1;
			steps++;
			rs = inst[11:10];
			rt = inst[9:8];
			rd = inst[7:6];
			immS = {{8{inst[7]}}, inst[7:0]};
			ea = regs[rs] + immS;
			case (inst[15:12])
				OP_BNE: if (regs[rs] != regs[rt]) pc = pc + immS;
				OP_BEQ: if (regs[rs] == regs[rt]) pc = pc + immS;
				OP_BGZ: if (!regs[rs][15] && regs[rs] != 16'd0) pc = pc + immS;
				OP_BLZ: if (regs[rs][15]) pc = pc + immS;
				OP_ADI: regs[rt] = ea;
				OP_ORI: regs[rt] = regs[rs] | {8'h00, inst[7:0]};
				OP_LHI: regs[rt] = {inst[7:0], 8'h00};
				OP_LWD: regs[rt] = refMem[ea[7:0]];
				OP_SWD: refMem[ea[7:0]] = regs[rt];
				OP_JMP: pc = {pc[15:12], inst[11:0]};
				OP_JAL: begin
					regs[LINK_REG] = pc;
					pc = {pc[15:12], inst[11:0]};
				end
				OP_RTYPE: begin
					case (inst[5:0])
						FUNC_ADD: regs[rd] = regs[rs] + regs[rt];
						FUNC_SUB: regs[rd] = regs[rs] - regs[rt];
						FUNC_AND: regs[rd] = regs[rs] & regs[rt];
						FUNC_ORR: regs[rd] = regs[rs] | regs[rt];
						FUNC_NOT: regs[rd] = ~regs[rs];
						FUNC_TCP: regs[rd] = 16'd0 - regs[rs];
						FUNC_SHL: regs[rd] = regs[rs] << 1;
						FUNC_SHR: regs[rd] = word_t'($signed(regs[rs]) >>> 1);
						FUNC_JPR: pc = regs[rs];
						FUNC_JRL: begin
							// jump register is read before the link is written
							target = regs[rs];
							regs[LINK_REG] = pc;
							pc = target;
						end
						FUNC_WWD: expectedTrace.push_back(regs[rs]);
						FUNC_HLT: halted = 1'b1;
						default: begin
							$display("reference met unsupported R-type word 0x%04h", inst);
							stopRun();
						end
					endcase
				end
				default: begin
					$display("reference met unsupported instruction 0x%04h", inst);
					stopRun();
				end
			endcase
		end
		return steps;
	endfunction

	// every cycle with outputValid consumes one expected WWD value
	always @(negedge clk) begin
		if (reset_n === 1'b1 && outputValid === 1'b1) begin
			if (traceIdx >= expectedTrace.size()) begin
				$display("outputPort gave more WWD values than the reference at %0t", $time);
				stopRun();
			end else begin
				checkValue("outputPort", outputPort, expectedTrace[traceIdx]);
				traceIdx++;
			end
		end
	end

	task automatic runOnDut(input string name);
		int count;
		count = runProgram();
		cycleLimit = cycleLimit + 9 * count + 50;
		@(posedge clk);
		#1;
		reset_n = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = image[i];
		end
		traceIdx = 0;
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;
		@(negedge clk);
		checkValue("readM", word_t'(readM), 16'h0);
		checkValue("writeM", word_t'(writeM), 16'h0);
		checkValue("outputValid", word_t'(outputValid), 16'h0);
		checkValue("isHalted", word_t'(isHalted), 16'h0);
		while (readM !== 1'b1) @(negedge clk);
		checkValue("address", address, 16'h0000);
		while (isHalted !== 1'b1) @(negedge clk);
		checkValue("wwdCount", word_t'(traceIdx), word_t'(expectedTrace.size()));
		repeat (20) begin
			@(negedge clk);
			checkValue("isHalted", word_t'(isHalted), 16'h1);
			checkValue("readM", word_t'(readM), 16'h0);
			checkValue("writeM", word_t'(writeM), 16'h0);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			checkValue($sformatf("mem[%0d]", i), mem[i], refMem[i]);
		end
		$display("%s: %0d instructions, %0d outputs matched", name, count, traceIdx);
	endtask

	task automatic aluProgram();
		clearImage();
		put(iType(OP_LHI, 2'd0, 2'd0, 8'h12));
		put(iType(OP_ORI, 2'd0, 2'd0, 8'h34));
		put(wwdInstr(2'd0));
		put(iType(OP_ADI, 2'd0, 2'd1, 8'hFB));
		put(wwdInstr(2'd1));
		put(iType(OP_LHI, 2'd0, 2'd2, 8'h80));
		// high immediate bit must not sign-extend for ORI
		put(iType(OP_ORI, 2'd2, 2'd2, 8'hF0));
		put(wwdInstr(2'd2));
		put(iType(OP_ADI, 2'd3, 2'd3, 8'h7F));
		put(wwdInstr(2'd3));
		for (int f = 0; f < 8; f++) begin
			put(rType(6'(f), 2'(f % 3), 2'((f + 1) % 3), 2'd3));
			put(wwdInstr(2'd3));
		end
		put(rType(FUNC_SHR, 2'd2, 2'd0, 2'd3));
		put(wwdInstr(2'd3));
		put(rType(FUNC_ADD, 2'd1, 2'd2, 2'd0));
		put(wwdInstr(2'd0));
		put(rType(FUNC_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	task automatic memoryProgram();
		clearImage();
		put(iType(OP_ADI, 2'd3, 2'd0, 8'h40));
		put(iType(OP_LHI, 2'd0, 2'd1, 8'hA5));
		put(iType(OP_ORI, 2'd1, 2'd1, 8'h5A));
		put(iType(OP_SWD, 2'd0, 2'd1, 8'h00));
		put(iType(OP_ADI, 2'd3, 2'd2, 8'hFF));
		put(iType(OP_SWD, 2'd0, 2'd2, 8'h01));
		put(iType(OP_SWD, 2'd0, 2'd0, 8'hFE));
		// 0xFFFF + 0x50 wraps to 0x004F
		put(iType(OP_SWD, 2'd2, 2'd1, 8'h50));
		put(iType(OP_LWD, 2'd0, 2'd3, 8'h00));
		put(wwdInstr(2'd3));
		put(iType(OP_LWD, 2'd0, 2'd3, 8'h01));
		put(wwdInstr(2'd3));
		put(iType(OP_LWD, 2'd0, 2'd2, 8'hFE));
		put(wwdInstr(2'd2));
		put(iType(OP_LWD, 2'd0, 2'd1, 8'h0F));
		put(wwdInstr(2'd1));
		put(iType(OP_LWD, 2'd0, 2'd1, 8'h03));
		put(wwdInstr(2'd1));
		put(rType(FUNC_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	task automatic branchProgram();
		clearImage();
		put(iType(OP_ADI, 2'd0, 2'd1, 8'h05));
		put(iType(OP_ADI, 2'd0, 2'd2, 8'hFD));
		put(iType(OP_BNE, 2'd1, 2'd0, 8'h01));
		put(wwdInstr(2'd1));
		put(iType(OP_BEQ, 2'd1, 2'd0, 8'h01));
		put(wwdInstr(2'd2));
		put(iType(OP_BGZ, 2'd1, 2'd0, 8'h01));
		put(wwdInstr(2'd1));
		put(iType(OP_BGZ, 2'd2, 2'd0, 8'h01));
		put(wwdInstr(2'd1));
		put(iType(OP_BLZ, 2'd2, 2'd0, 8'h01));
		put(wwdInstr(2'd2));
		put(iType(OP_BLZ, 2'd1, 2'd0, 8'h01));
		put(iType(OP_BEQ, 2'd1, 2'd1, 8'h01));
		put(wwdInstr(2'd1));
		put(iType(OP_BNE, 2'd1, 2'd1, 8'h01));
		put(jType(OP_JMP, 12'd18));
		put(wwdInstr(2'd1));
		put(jType(OP_JAL, 12'd30));
		put(wwdInstr(2'd2));
		put(iType(OP_ADI, 2'd0, 2'd1, 8'd32));
		put(rType(FUNC_JRL, 2'd1, 2'd0, 2'd0));
		put(wwdInstr(2'd2));
		// counting loop with a backward branch
		put(iType(OP_ADI, 2'd3, 2'd3, 8'h01));
		put(iType(OP_ADI, 2'd0, 2'd1, 8'h03));
		put(iType(OP_BNE, 2'd3, 2'd1, 8'hFD));
		put(wwdInstr(2'd3));
		put(rType(FUNC_HLT, 2'd0, 2'd0, 2'd0));
		// subroutines at 30 and 32
		putPtr = 30;
		put(wwdInstr(2'd2));
		put(rType(FUNC_JPR, 2'd2, 2'd0, 2'd0));
		put(wwdInstr(2'd2));
		put(rType(FUNC_JPR, 2'd2, 2'd0, 2'd0));
	endtask

	task automatic randomProgram();
		int         kind;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [7:0] imm;
		clearImage();
		repeat (30) begin
			kind = $urandom % 11;
			rs = 2'($urandom);
			rt = 2'($urandom);
			rd = 2'($urandom);
			imm = 8'($urandom);
			case (kind)
				8: put(iType(OP_ADI, rs, rt, imm));
				9: put(iType(OP_ORI, rs, rt, imm));
				10: put(iType(OP_LHI, rs, rt, imm));
				default: put(rType(6'(kind), rs, rt, rd));
			endcase
		end
		for (int r = 0; r < 4; r++) begin
			put(wwdInstr(2'(r)));
		end
		put(rType(FUNC_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	initial begin
		reset_n = 1'b0;
		void'($urandom(32'hb1e04ffd));
		aluProgram();
		runOnDut("alu");
		memoryProgram();
		runOnDut("memory");
		branchProgram();
		runOnDut("branch");
		for (int p = 0; p < 10; p++) begin
			randomProgram();
			runOnDut($sformatf("random %0d", p));
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule
